/* hdl/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit
    import id_pkg::*;
(
    input  wire [xlen-1:0]  pc_i,
    input  wire [xlen-1:0]  inst_i,
    input  dec_ctrl_t       ctrl_i,
    input  wire [xlen-1:0]  rj_data_i,
    input  wire [xlen-1:0]  rk_data_i,
    output logic            taken_o,
    output logic [xlen-1:0] target_o
);

    logic [xlen-1:0] offs16;
    logic [xlen-1:0] offs26;
    logic            eq;
    logic            lt_s;
    logic            lt_u;

    // word offsets, offs26 high part sits in inst[9:0]
    assign offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    // rk data holds rd for the compare forms
    assign eq   = (rj_data_i == rk_data_i);
    assign lt_s = ($signed(rj_data_i) < $signed(rk_data_i));
    assign lt_u = (rj_data_i < rk_data_i);

    always_comb begin
        case (ctrl_i.jbr_kind)
            jbr_jirl, jbr_b, jbr_bl: taken_o = 1'b1;
            jbr_beq:                 taken_o = eq;
            jbr_bne:                 taken_o = !eq;
            jbr_blt:                 taken_o = lt_s;
            jbr_bge:                 taken_o = !lt_s;
            jbr_bltu:                taken_o = lt_u;
            jbr_bgeu:                taken_o = !lt_u;
            default:                 taken_o = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    always_comb begin
        case (ctrl_i.jbr_kind)
            jbr_jirl:    target_o = rj_data_i + offs16;
            jbr_b, jbr_bl: target_o = pc_i + offs26;
            default:     target_o = pc_i + offs16;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/hazard_check.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_check
    import id_pkg::*;
(
    input  dec_ctrl_t             ctrl_i,
    input  wire [reg_addr_w-1:0]  rj_addr_i,
    input  wire [reg_addr_w-1:0]  rk_addr_i,
    input  wire [reg_addr_w-1:0]  ex_dest_i,
    input  wire [reg_addr_w-1:0]  mem_dest_i,
    input  wire [reg_addr_w-1:0]  wb_dest_i,
    output logic                  hazard_o
);

    logic rj_pending;
    logic rk_pending;

    // any downstream stage still owes a write to this register
    assign rj_pending = (rj_addr_i == ex_dest_i) || (rj_addr_i == mem_dest_i) ||
                        (rj_addr_i == wb_dest_i);
    assign rk_pending = (rk_addr_i == ex_dest_i) || (rk_addr_i == mem_dest_i) ||
                        (rk_addr_i == wb_dest_i);

    // r0 is constant, never wait on it
    assign hazard_o = (ctrl_i.uses_rj && rj_addr_i != '0 && rj_pending) ||
                      (ctrl_i.uses_rk && rk_addr_i != '0 && rk_pending);

endmodule

`default_nettype wire

/* hdl/id_pkg.sv */
`default_nettype none

package id_pkg;

    // datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // three-register and shift-immediate ops on inst[31:15]
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_sll_w  = 17'h0002e;
    localparam logic [16:0] op_srl_w  = 17'h0002f;
    localparam logic [16:0] op_sra_w  = 17'h00030;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // 12-bit immediate ops on inst[31:22]
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltui  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // 20-bit immediate ops on inst[31:25]
    localparam logic [6:0] op_lu12i_w   = 7'h0a;
    localparam logic [6:0] op_pcaddu12i = 7'h0e;

    // jumps and branches on inst[31:26]
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;
    localparam logic [5:0] op_blt  = 6'h18;
    localparam logic [5:0] op_bge  = 6'h19;
    localparam logic [5:0] op_bltu = 6'h1a;
    localparam logic [5:0] op_bgeu = 6'h1b;

    // one-hot alu class, add sits in the msb
    typedef struct packed {
        logic add_op;
        logic sub_op;
        logic slt_op;
        logic sltu_op;
        logic and_op;
        logic nor_op;
        logic or_op;
        logic xor_op;
        logic sll_op;
        logic srl_op;
        logic sra_op;
        logic lui_op;
    } alu_op_t;

    typedef enum logic [1:0] {
        imm_none,
        imm_zero12,
        imm_sign12,
        imm_sign20
    } imm_kind_t;

    typedef enum logic [3:0] {
        jbr_none,
        jbr_jirl,
        jbr_b,
        jbr_bl,
        jbr_beq,
        jbr_bne,
        jbr_blt,
        jbr_bge,
        jbr_bltu,
        jbr_bgeu
    } jbr_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        imm_kind_t imm_kind;
        jbr_kind_t jbr_kind;
        logic      is_load;
        logic      is_store;
        logic      uses_rj;
        logic      uses_rk;
        logic      rk_from_rd;
        logic      link;
        logic      pc_as_src1;
        logic      dest_r1;
        logic      no_dest;
    } dec_ctrl_t;

    // fetch to decode payload
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } if_id_t;

    // decode to execute payload
    typedef struct packed {
        alu_op_t               alu_op;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] dest;
        logic                  dest_we;
        logic                  is_load;
        logic                  is_store;
        logic [xlen-1:0]       pc;
    } id_ex_t;

endpackage

`default_nettype wire

/* hdl/id_stage_top.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage_top
    import id_pkg::*;
(
    input  wire                   clk_i,
    input  wire                   reset_i,
    // fetch side
    input  wire                   if_valid_i,
    input  wire [xlen-1:0]        if_pc_i,
    input  wire [xlen-1:0]        if_inst_i,
    output logic                  if_ready_o,
    input  wire                   if_over_i,
    output logic                  jbr_taken_o,
    output logic [xlen-1:0]       jbr_target_o,
    // execute side
    output logic                  ex_valid_o,
    output alu_op_t               ex_alu_op_o,
    output logic [xlen-1:0]       ex_src1_o,
    output logic [xlen-1:0]       ex_src2_o,
    output logic [xlen-1:0]       ex_store_data_o,
    output logic [reg_addr_w-1:0] ex_dest_o,
    output logic                  ex_dest_we_o,
    output logic                  ex_is_load_o,
    output logic                  ex_is_store_o,
    output logic [xlen-1:0]       ex_pc_o,
    input  wire                   ex_ready_i,
    // register file
    output logic [reg_addr_w-1:0] rj_addr_o,
    output logic [reg_addr_w-1:0] rk_addr_o,
    input  wire [xlen-1:0]        rj_data_i,
    input  wire [xlen-1:0]        rk_data_i,
    // pending writes downstream
    input  wire [reg_addr_w-1:0]  ex_dest_i,
    input  wire [reg_addr_w-1:0]  mem_dest_i,
    input  wire [reg_addr_w-1:0]  wb_dest_i
);

    if_id_t                if_bundle;
    if_id_t                id_bundle;
    id_ex_t                id_out;
    id_ex_t                ex_bundle;
    dec_ctrl_t             ctrl;
    logic                  id_valid;
    logic                  id_ready_go;
    logic                  id_leave;
    logic                  ex_in_ready;
    logic                  hazard;
    logic                  taken;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] dest;
    logic                  dest_we;

    assign if_bundle = '{pc: if_pc_i, inst: if_inst_i};

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk_i, .reset_i,
        .in_valid_i(if_valid_i), .in_data_i(if_bundle), .in_ready_o(if_ready_o),
        .out_valid_o(id_valid), .out_data_o(id_bundle), .out_ready_i(id_leave)
    );

    inst_decoder decoder (.inst_i(id_bundle.inst), .ctrl_o(ctrl));

    operand_mux operands (
        .inst_i(id_bundle.inst), .pc_i(id_bundle.pc), .ctrl_i(ctrl),
        .rj_data_i, .rk_data_i, .rj_addr_o, .rk_addr_o,
        .src1_o(src1), .src2_o(src2), .store_data_o(store_data),
        .dest_o(dest), .dest_we_o(dest_we)
    );

    branch_unit branch (
        .pc_i(id_bundle.pc), .inst_i(id_bundle.inst), .ctrl_i(ctrl),
        .rj_data_i, .rk_data_i, .taken_o(taken), .target_o(jbr_target_o)
    );

    hazard_check hazards (
        .ctrl_i(ctrl), .rj_addr_i(rj_addr_o), .rk_addr_i(rk_addr_o),
        .ex_dest_i, .mem_dest_i, .wb_dest_i, .hazard_o(hazard)
    );

    // jumps wait until fetch has closed its current access
    assign id_ready_go = id_valid && !hazard && (ctrl.jbr_kind == jbr_none || if_over_i);
    assign id_leave    = id_ready_go && ex_in_ready;
    // redirect only with the actual departure
    assign jbr_taken_o = taken && id_leave;

    assign id_out = '{alu_op: ctrl.alu_op, src1: src1, src2: src2, store_data: store_data,
                      dest: dest, dest_we: dest_we, is_load: ctrl.is_load,
                      is_store: ctrl.is_store, pc: id_bundle.pc};

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk_i, .reset_i,
        .in_valid_i(id_ready_go), .in_data_i(id_out), .in_ready_o(ex_in_ready),
        .out_valid_o(ex_valid_o), .out_data_o(ex_bundle), .out_ready_i(ex_ready_i)
    );

    assign ex_alu_op_o     = ex_bundle.alu_op;
    assign ex_src1_o       = ex_bundle.src1;
    assign ex_src2_o       = ex_bundle.src2;
    assign ex_store_data_o = ex_bundle.store_data;
    assign ex_dest_o       = ex_bundle.dest;
    assign ex_dest_we_o    = ex_bundle.dest_we;
    assign ex_is_load_o    = ex_bundle.is_load;
    assign ex_is_store_o   = ex_bundle.is_store;
    assign ex_pc_o         = ex_bundle.pc;

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
    import id_pkg::*;
(
    input  wire [xlen-1:0] inst_i,
    output dec_ctrl_t      ctrl_o
);

    // opcode fields of the four formats
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    assign op17 = inst_i[31:15];
    assign op10 = inst_i[31:22];
    assign op7  = inst_i[31:25];
    assign op6  = inst_i[31:26];

    always_comb begin
        ctrl_o = '0;

        // 3r forms and shift-immediates
        case (op17)
            op_add_w:            ctrl_o.alu_op.add_op = 1'b1;
            op_sub_w:            ctrl_o.alu_op.sub_op = 1'b1;
            op_slt:              ctrl_o.alu_op.slt_op = 1'b1;
            op_sltu:             ctrl_o.alu_op.sltu_op = 1'b1;
            op_and:              ctrl_o.alu_op.and_op = 1'b1;
            op_nor:              ctrl_o.alu_op.nor_op = 1'b1;
            op_or:               ctrl_o.alu_op.or_op = 1'b1;
            op_xor:              ctrl_o.alu_op.xor_op = 1'b1;
            op_sll_w, op_slli_w: ctrl_o.alu_op.sll_op = 1'b1;
            op_srl_w, op_srli_w: ctrl_o.alu_op.srl_op = 1'b1;
            op_sra_w, op_srai_w: ctrl_o.alu_op.sra_op = 1'b1;
            default:             ;
        endcase
        // ui5 lives in inst[14:10] so zero12 hands it over in the low bits
        if (op17 inside {op_slli_w, op_srli_w, op_srai_w}) begin
            ctrl_o.imm_kind = imm_zero12;
        end else if (ctrl_o.alu_op != '0) begin
            ctrl_o.uses_rk = 1'b1;
        end

        // 12-bit immediate forms
        case (op10)
            op_slti:                     ctrl_o.alu_op.slt_op = 1'b1;
            op_sltui:                    ctrl_o.alu_op.sltu_op = 1'b1;
            op_addi_w, op_ld_w, op_st_w: ctrl_o.alu_op.add_op = 1'b1;
            op_andi:                     ctrl_o.alu_op.and_op = 1'b1;
            op_ori:                      ctrl_o.alu_op.or_op = 1'b1;
            op_xori:                     ctrl_o.alu_op.xor_op = 1'b1;
            default:                     ;
        endcase
        // logic immediates are zero extended
        if (op10 inside {op_andi, op_ori, op_xori}) begin
            ctrl_o.imm_kind = imm_zero12;
        end else if (op10 inside {op_slti, op_sltui, op_addi_w, op_ld_w, op_st_w}) begin
            ctrl_o.imm_kind = imm_sign12;
        end
        ctrl_o.is_load  = (op10 == op_ld_w);
        ctrl_o.is_store = (op10 == op_st_w);

        // lu12i.w passes si20 through, pcaddu12i adds it to pc
        if (op7 == op_lu12i_w) begin
            ctrl_o.alu_op.lui_op = 1'b1;
            ctrl_o.imm_kind      = imm_sign20;
        end
        if (op7 == op_pcaddu12i) begin
            ctrl_o.alu_op.add_op = 1'b1;
            ctrl_o.imm_kind      = imm_sign20;
            ctrl_o.pc_as_src1    = 1'b1;
        end

        case (op6)
            op_jirl: ctrl_o.jbr_kind = jbr_jirl;
            op_b:    ctrl_o.jbr_kind = jbr_b;
            op_bl:   ctrl_o.jbr_kind = jbr_bl;
            op_beq:  ctrl_o.jbr_kind = jbr_beq;
            op_bne:  ctrl_o.jbr_kind = jbr_bne;
            op_blt:  ctrl_o.jbr_kind = jbr_blt;
            op_bge:  ctrl_o.jbr_kind = jbr_bge;
            op_bltu: ctrl_o.jbr_kind = jbr_bltu;
            op_bgeu: ctrl_o.jbr_kind = jbr_bgeu;
            default: ;
        endcase

        // links write pc+4 through the adder
        ctrl_o.link    = ctrl_o.jbr_kind inside {jbr_jirl, jbr_bl};
        ctrl_o.dest_r1 = (ctrl_o.jbr_kind == jbr_bl);
        if (ctrl_o.link) begin
            ctrl_o.alu_op.add_op = 1'b1;
            ctrl_o.pc_as_src1    = 1'b1;
        end
        // compares and stores read rd on the rk port
        ctrl_o.rk_from_rd = ctrl_o.is_store ||
            (ctrl_o.jbr_kind inside {jbr_beq, jbr_bne, jbr_blt, jbr_bge, jbr_bltu, jbr_bgeu});
        if (ctrl_o.rk_from_rd) begin
            ctrl_o.uses_rk = 1'b1;
        end
        ctrl_o.uses_rj = (ctrl_o.alu_op != '0 || ctrl_o.jbr_kind != jbr_none) &&
            ctrl_o.imm_kind != imm_sign20 && !(ctrl_o.jbr_kind inside {jbr_b, jbr_bl});
        // unknown encodings land here with no alu class
        ctrl_o.no_dest = (ctrl_o.alu_op == '0) || ctrl_o.is_store;
    end

    // formats never overlap, so at most one alu class
    always_comb begin
        assert final ($onehot0(ctrl_o.alu_op))
            else $error("decoder raised more than one alu class");
    end

endmodule

`default_nettype wire

/* hdl/operand_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_mux
    import id_pkg::*;
(
    input  wire [xlen-1:0]        inst_i,
    input  wire [xlen-1:0]        pc_i,
    input  dec_ctrl_t             ctrl_i,
    input  wire [xlen-1:0]        rj_data_i,
    input  wire [xlen-1:0]        rk_data_i,
    output logic [reg_addr_w-1:0] rj_addr_o,
    output logic [reg_addr_w-1:0] rk_addr_o,
    output logic [xlen-1:0]       src1_o,
    output logic [xlen-1:0]       src2_o,
    output logic [xlen-1:0]       store_data_o,
    output logic [reg_addr_w-1:0] dest_o,
    output logic                  dest_we_o
);

    // rk [14:10]   rj [9:5]   rd [4:0]
    assign rj_addr_o = inst_i[9:5];
    assign rk_addr_o = ctrl_i.rk_from_rd ? inst_i[4:0] : inst_i[14:10];

    assign src1_o = ctrl_i.pc_as_src1 ? pc_i : rj_data_i;

    always_comb begin
        if (ctrl_i.link) begin
            // return address is pc+4
            src2_o = 32'd4;
        end else begin
            case (ctrl_i.imm_kind)
                imm_zero12: src2_o = {20'd0, inst_i[21:10]};
                imm_sign12: src2_o = {{20{inst_i[21]}}, inst_i[21:10]};
                imm_sign20: src2_o = {inst_i[24:5], 12'd0};
                default:    src2_o = rk_data_i;
            endcase
        end
    end

    // st.w data comes from rd via the rk port
    assign store_data_o = rk_data_i;

    // bl always links into r1
    always_comb begin
        if (ctrl_i.no_dest) begin
            dest_o = '0;
        end else if (ctrl_i.dest_r1) begin
            dest_o = 5'd1;
        end else begin
            dest_o = inst_i[4:0];
        end
    end
    assign dest_we_o = !ctrl_i.no_dest;

endmodule

`default_nettype wire

/* hdl/stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk_i,
    input  wire      reset_i,
    input  wire      in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  wire      out_ready_i
);

    logic     valid_q;
    payload_t data_q;
    logic     load;

    // free slot, or the held item leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            // drained with nothing new behind it
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // stalled payload must not move under the consumer
    a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> $stable(out_data_o));

    a_empty_after_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid_o);

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hdl/id_pkg.sv
hdl/stage_reg.sv
hdl/inst_decoder.sv
hdl/operand_mux.sv
hdl/branch_unit.sv
hdl/hazard_check.sv
hdl/id_stage_top.sv
test/id_stage_tb.sv

/* include/id_ref_model.svh */
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// needs id_pkg imported by the including scope

// register file contents as seen by decode, r0 reads zero
function automatic logic [31:0] regfile_word(input logic [4:0] addr);
    return (addr == 5'd0) ? 32'd0 : 32'h9e37_79b9 * {27'd0, addr};
endfunction

// expected execute bundle and redirect for one instruction
function automatic id_ex_t id_ref_model(
    input  logic [31:0] pc,
    input  logic [31:0] inst,
    output logic        taken,
    output logic [31:0] target
);
    id_ex_t      e;
    logic [16:0] r3;
    logic [9:0]  i12;
    logic [6:0]  i20;
    logic [5:0]  o6;
    logic        link, cond, no_dest;
    logic [31:0] rj, rk, off16;
    r3 = inst[31:15];
    i12 = inst[31:22];
    i20 = inst[31:25];
    o6 = inst[31:26];
    link = (o6 == op_jirl) || (o6 == op_bl);
    cond = (o6 >= op_beq) && (o6 <= op_bgeu);
    // compares and stores read rd on the second port
    rj = regfile_word(inst[9:5]);
    rk = regfile_word((cond || i12 == op_st_w) ? inst[4:0] : inst[14:10]);
    off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    e = '0;
    e.alu_op.add_op = (r3 == op_add_w) || (i12 inside {op_addi_w, op_ld_w, op_st_w}) ||
                      link || (i20 == op_pcaddu12i);
    e.alu_op.sub_op = (r3 == op_sub_w);
    e.alu_op.slt_op = (r3 == op_slt) || (i12 == op_slti);
    e.alu_op.sltu_op = (r3 == op_sltu) || (i12 == op_sltui);
    e.alu_op.and_op = (r3 == op_and) || (i12 == op_andi);
    e.alu_op.nor_op = (r3 == op_nor);
    e.alu_op.or_op = (r3 == op_or) || (i12 == op_ori);
    e.alu_op.xor_op = (r3 == op_xor) || (i12 == op_xori);
    e.alu_op.sll_op = r3 inside {op_sll_w, op_slli_w};
    e.alu_op.srl_op = r3 inside {op_srl_w, op_srli_w};
    e.alu_op.sra_op = r3 inside {op_sra_w, op_srai_w};
    e.alu_op.lui_op = (i20 == op_lu12i_w);
    e.is_load = (i12 == op_ld_w);
    e.is_store = (i12 == op_st_w);
    e.src1 = (link || i20 == op_pcaddu12i) ? pc : rj;
    // shift amount rides in the low bits of the zero-extended field
    if (link)
        e.src2 = 32'd4;
    else if (r3 inside {op_slli_w, op_srli_w, op_srai_w} || i12 inside {op_andi, op_ori, op_xori})
        e.src2 = {20'd0, inst[21:10]};
    else if (i12 inside {op_slti, op_sltui, op_addi_w, op_ld_w, op_st_w})
        e.src2 = {{20{inst[21]}}, inst[21:10]};
    else if (i20 inside {op_lu12i_w, op_pcaddu12i})
        e.src2 = {inst[24:5], 12'd0};
    else
        e.src2 = rk;
    e.store_data = rk;
    no_dest = (e.alu_op == '0) || e.is_store;
    e.dest_we = !no_dest;
    e.dest = no_dest ? 5'd0 : (o6 == op_bl) ? 5'd1 : inst[4:0];
    e.pc = pc;
    taken = 1'b0;
    target = pc + off16;
    case (o6)
        op_jirl: begin
            taken = 1'b1;
            target = rj + off16;
        end
        op_b, op_bl: begin
            taken = 1'b1;
            target = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
        op_beq:  taken = (rj == rk);
        op_bne:  taken = (rj != rk);
        op_blt:  taken = ($signed(rj) < $signed(rk));
        op_bge:  taken = ($signed(rj) >= $signed(rk));
        op_bltu: taken = (rj < rk);
        op_bgeu: taken = (rj >= rk);
        default: target = 32'd0;
    endcase
    return e;
endfunction

`endif

/* test/id_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb
    import id_pkg::*;
();

    `include "id_ref_model.svh"

    localparam int n_inst     = 400;
    localparam int wait_limit = 200;

    logic                  clk_i;
    logic                  reset_i;
    logic                  if_valid_i;
    logic [xlen-1:0]       if_pc_i;
    logic [xlen-1:0]       if_inst_i;
    logic                  if_ready_o;
    logic                  if_over_i;
    logic                  jbr_taken_o;
    logic [xlen-1:0]       jbr_target_o;
    logic                  ex_valid_o;
    alu_op_t               ex_alu_op_o;
    logic [xlen-1:0]       ex_src1_o;
    logic [xlen-1:0]       ex_src2_o;
    logic [xlen-1:0]       ex_store_data_o;
    logic [reg_addr_w-1:0] ex_dest_o;
    logic                  ex_dest_we_o;
    logic                  ex_is_load_o;
    logic                  ex_is_store_o;
    logic [xlen-1:0]       ex_pc_o;
    logic                  ex_ready_i;
    logic [reg_addr_w-1:0] rj_addr_o;
    logic [reg_addr_w-1:0] rk_addr_o;
    logic [xlen-1:0]       rj_data_i;
    logic [xlen-1:0]       rk_data_i;
    logic [reg_addr_w-1:0] ex_dest_i;
    logic [reg_addr_w-1:0] mem_dest_i;
    logic [reg_addr_w-1:0] wb_dest_i;

    integer seed;
    logic   random_flow;
    int     issued_count;
    int     received_count;

    // expected bundles and redirects, in issue order
    id_ex_t          exp_q[$];
    logic            taken_q[$];
    logic [xlen-1:0] target_q[$];
    // redirects seen on the fetch side, not yet matched
    logic [xlen-1:0] redir_q[$];

    id_ex_t          got_exp;
    logic            got_taken;
    logic [xlen-1:0] got_target;

    // opcode pools for the random mix
    logic [16:0] ops17 [14] = '{op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and, op_or,
                                op_xor, op_sll_w, op_srl_w, op_sra_w, op_slli_w, op_srli_w,
                                op_srai_w};
    logic [9:0]  ops10 [8]  = '{op_slti, op_sltui, op_addi_w, op_andi, op_ori, op_xori,
                                op_ld_w, op_st_w};
    logic [6:0]  ops7  [2]  = '{op_lu12i_w, op_pcaddu12i};
    logic [5:0]  ops6  [9]  = '{op_jirl, op_b, op_bl, op_beq, op_bne, op_blt, op_bge,
                                op_bltu, op_bgeu};

    id_stage_top id_stage_top_i (.*);

    // register file answers in the same cycle
    assign rj_data_i = regfile_word(rj_addr_o);
    assign rk_data_i = regfile_word(rk_addr_o);

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // opcode from the pool, every other field random
    function automatic logic [31:0] random_inst(input int pick, input logic [31:0] r);
        if (pick < 14)
            return {ops17[pick], r[14:0]};
        else if (pick < 22)
            return {ops10[pick-14], r[21:0]};
        else if (pick < 24)
            return {ops7[pick-22], r[24:0]};
        else if (pick < 33)
            return {ops6[pick-24], r[25:0]};
        else
            return 32'd0;
    endfunction

    // fetch side, holds the pair until the stage takes it
    task automatic issue(input logic [31:0] pc, input logic [31:0] inst);
        id_ex_t      e;
        logic        tk;
        logic [31:0] tg;
        int          waited;
        e = id_ref_model(pc, inst, tk, tg);
        exp_q.push_back(e);
        taken_q.push_back(tk);
        target_q.push_back(tg);
        issued_count++;
        @(negedge clk_i);
        if_valid_i = 1'b1;
        if_pc_i    = pc;
        if_inst_i  = inst;
        waited     = 0;
        @(posedge clk_i);
        while (!if_ready_o) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout: decode never accepted an instruction from fetch");
            end
            @(posedge clk_i);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk_i);
        if_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout: issued instructions never reached execute");
            end
            @(negedge clk_i);
        end
    endtask

    // pending write on a used source must keep add.w r3, r5, r7 in decode
    task automatic hazard_hold(input logic [4:0] ex_d, input logic [4:0] mem_d,
                               input logic [4:0] wb_d);
        @(negedge clk_i);
        ex_dest_i  = ex_d;
        mem_dest_i = mem_d;
        wb_dest_i  = wb_d;
        issue(32'h0000_1000, {op_add_w, 5'd7, 5'd5, 5'd3});
        @(negedge clk_i);
        if_valid_i = 1'b0;
        repeat (6) begin
            @(posedge clk_i);
            check("ex_valid_o during hazard", ex_valid_o, 1'b0);
        end
        @(negedge clk_i);
        ex_dest_i  = '0;
        mem_dest_i = '0;
        wb_dest_i  = '0;
        wait_drain();
    endtask

    // execute side and fetch readiness
    always @(negedge clk_i) begin
        if (random_flow) begin
            ex_ready_i = ($random(seed) & 3) != 0;
            if_over_i  = ($random(seed) & 1) != 0;
        end else begin
            ex_ready_i = 1'b1;
            if_over_i  = 1'b1;
        end
    end

    // compare process, one expected bundle per execute transfer
    always @(posedge clk_i) begin
        if (!reset_i && ex_valid_o && ex_ready_i) begin
            if (exp_q.size() == 0) begin
                abort_run("execute transfer happened with no instruction outstanding");
            end else begin
                got_exp    = exp_q.pop_front();
                got_taken  = taken_q.pop_front();
                got_target = target_q.pop_front();
                check("ex_alu_op_o", ex_alu_op_o, got_exp.alu_op);
                check("ex_src1_o", ex_src1_o, got_exp.src1);
                check("ex_src2_o", ex_src2_o, got_exp.src2);
                check("ex_store_data_o", ex_store_data_o, got_exp.store_data);
                check("ex_dest_o", ex_dest_o, got_exp.dest);
                check("ex_dest_we_o", ex_dest_we_o, got_exp.dest_we);
                check("ex_is_load_o", ex_is_load_o, got_exp.is_load);
                check("ex_is_store_o", ex_is_store_o, got_exp.is_store);
                check("ex_pc_o", ex_pc_o, got_exp.pc);
                // a taken jump pulsed exactly once on its way into execute
                if (got_taken) begin
                    check("redirect pulses", redir_q.size(), 1);
                    check("jbr_target_o", redir_q.pop_front(), got_target);
                end else begin
                    check("redirect pulses", redir_q.size(), 0);
                end
                received_count++;
            end
        end
        if (!reset_i && jbr_taken_o) begin
            redir_q.push_back(jbr_target_o);
        end
    end

    initial begin
        int          pick;
        logic [31:0] pc;
        seed           = 32'h4ba8;
        random_flow    = 1'b0;
        issued_count   = 0;
        received_count = 0;
        reset_i        = 1'b1;
        if_valid_i     = 1'b0;
        if_pc_i        = '0;
        if_inst_i      = '0;
        if_over_i      = 1'b1;
        ex_ready_i     = 1'b1;
        ex_dest_i      = '0;
        mem_dest_i     = '0;
        wb_dest_i      = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        check("ex_valid_o after reset", ex_valid_o, 1'b0);
        check("jbr_taken_o after reset", jbr_taken_o, 1'b0);
        check("if_ready_o after reset", if_ready_o, 1'b1);

        // raw hazards through each downstream stage
        hazard_hold(5'd5, 5'd0, 5'd0);
        hazard_hold(5'd0, 5'd7, 5'd0);
        hazard_hold(5'd0, 5'd0, 5'd5);
        // r0 sources go straight through while idle stages also read as r0
        issue(32'h0000_2000, {op_add_w, 5'd0, 5'd0, 5'd3});
        wait_drain();

        // random mix under back-pressure and slow fetch
        random_flow = 1'b1;
        repeat (n_inst) begin
            pick = {$random(seed)} % 34;
            pc   = $random(seed) & 32'hffff_fffc;
            issue(pc, random_inst(pick, $random(seed)));
        end
        wait_drain();
        random_flow = 1'b0;
        repeat (2) @(negedge clk_i);

        if (received_count == issued_count && redir_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("count mismatch: %0d issued, %0d received, %0d stray redirects",
                                issued_count, received_count, redir_q.size()));
        end
    end

endmodule

`default_nettype wire
